/* sim.f */
io_pkg.sv
uart_tx.sv
gpio.sv
io_timer.sv
interrupt_controller.sv
scratch_ram.sv
port_controller.sv
tb_port_controller.sv

/* run_sim.sh */
#!/bin/sh
# build and run the port controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_port_controller -f sim.f -o sim_bin > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_bin > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

/* tb_port_controller.sv */
// testbench with clock, reset, stimulus table, compare tasks, uart frame monitor and watchdog
`default_nettype none

module tb_port_controller
	import io_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BAUD_RATE  = 100000;
	localparam int CLOCK_FREQ = 4 * BAUD_RATE;
	localparam int BIT_CLKS   = CLOCK_FREQ / BAUD_RATE;
	localparam int POLL_LIMIT = 20 * BIT_CLKS;

	typedef enum logic [3:0] {
		OP_WR, OP_RD, OP_WAIT, OP_PINS, OP_OUT, OP_IRQ, OP_TX, OP_FRAME, OP_POLL
	} op_t;

	// data doubles as wait count, pin value, frame byte or expected interrupt line
	typedef struct packed {
		op_t        op;
		logic [3:0] test;
		addr_t      addr;
		data_t      data;
		data_t      exp;
	} step_t;

	logic       CLK;
	logic       RSTb;
	io_req_t    req;
	data_t      rdata;
	logic [5:0] gpio_in;
	logic [3:0] gpio_out;
	logic       uart_tx;
	irq_num_t   irq;
	logic       interrupt;

	step_t       steps [$];
	int          build_test;
	int          cur_test;
	int          errors;
	int          checks;
	int          test_errs;
	int          tests_done;
	logic        table_ready;
	logic [31:0] rnd_state;
	string       test_name [5] = '{"reset", "decode", "gpio", "timer", "uart"};

	port_controller #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) dut (
		.CLK(CLK), .RSTb(RSTb), .req(req), .rdata(rdata), .gpio_in(gpio_in),
		.gpio_out(gpio_out), .uart_tx(uart_tx), .irq(irq), .interrupt(interrupt)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic void add_step(op_t op, addr_t addr, data_t data, data_t exp);
		step_t s;
		s.op   = op;
		s.test = 4'(build_test);
		s.addr = addr;
		s.data = data;
		s.exp  = exp;
		steps.push_back(s);
	endfunction

	task automatic build_table();
		ram_addr_t ram_a [6];
		data_t     ram_d [6];
		build_test = 0;
		add_step(OP_TX, 16'h0000, 16'h0000, 16'h0001);
		add_step(OP_OUT, 16'h0000, 16'h0000, 16'h0000);
		add_step(OP_IRQ, 16'h0000, 16'h0000, 16'h0000);
		add_step(OP_RD, 16'h7001, 16'h0000, 16'h0000);	// interrupt enable
		add_step(OP_RD, 16'h1002, 16'h0000, 16'h0000);	// gpio mask
		add_step(OP_RD, 16'h9001, 16'h0000, 16'h0000);	// timer control
		build_test = 1;
		add_step(OP_WR, 16'h1000, 16'h000a, 16'h0000);
		add_step(OP_RD, 16'h1000, 16'h0000, 16'h000a);
		add_step(OP_WR, 16'h1002, 16'h0015, 16'h0000);
		add_step(OP_RD, 16'h1002, 16'h0000, 16'h0015);
		add_step(OP_WR, 16'h9000, 16'h1234, 16'h0000);
		add_step(OP_RD, 16'h9000, 16'h0000, 16'h1234);
		add_step(OP_RD, 16'h9002, 16'h0000, 16'h1234);	// reload write loads the count
		for (int k = 0; k < 6; k++) begin
			ram_a[k]  = ram_addr_t'(k * 83 + 5);
			rnd_state = xorshift(rnd_state);
			ram_d[k]  = rnd_state[15:0];
			add_step(OP_WR, {4'h8, 3'b000, ram_a[k]}, ram_d[k], 16'h0000);
		end
		for (int k = 0; k < 6; k++) begin
			add_step(OP_RD, {4'h8, 3'b000, ram_a[k]}, 16'h0000, ram_d[k]);
		end
		for (int r = 2; r <= 10; r++) begin
			if (r <= 6 || r == 10) begin	// unmapped regions
				add_step(OP_WR, {4'(r), 12'h000}, 16'hffff, 16'h0000);
				add_step(OP_RD, {4'(r), 12'h000}, 16'h0000, 16'h0000);
			end
		end
		add_step(OP_RD, 16'h1000, 16'h0000, 16'h000a);
		add_step(OP_RD, 16'h9000, 16'h0000, 16'h1234);
		add_step(OP_RD, 16'h0000, 16'h0000, 16'h0000);	// no frame was started
		build_test = 2;
		add_step(OP_WR, 16'h1002, 16'h0000, 16'h0000);
		add_step(OP_WR, 16'h1000, 16'h0005, 16'h0000);
		add_step(OP_OUT, 16'h0000, 16'h0000, 16'h0005);
		add_step(OP_PINS, 16'h0000, 16'h002c, 16'h0000);
		add_step(OP_WAIT, 16'h0000, 16'h0002, 16'h0000);	// two sync flops
		add_step(OP_RD, 16'h1001, 16'h0000, 16'h002c);
		add_step(OP_WR, 16'h7000, 16'h0007, 16'h0000);
		add_step(OP_WR, 16'h7001, 16'h0002, 16'h0000);
		add_step(OP_WR, 16'h1002, 16'h0001, 16'h0000);
		add_step(OP_PINS, 16'h0000, 16'h002d, 16'h0000);	// pin 0 rises
		add_step(OP_WAIT, 16'h0000, 16'h0004, 16'h0000);
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0002);
		add_step(OP_IRQ, 16'h0000, 16'h0001, 16'h0002);
		add_step(OP_WR, 16'h7000, 16'h0002, 16'h0000);
		add_step(OP_WAIT, 16'h0000, 16'h0001, 16'h0000);
		add_step(OP_IRQ, 16'h0000, 16'h0000, 16'h0000);
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0000);
		build_test = 3;
		add_step(OP_WR, 16'h7001, 16'h0001, 16'h0000);
		add_step(OP_WR, 16'h9000, 16'd10, 16'h0000);
		add_step(OP_WR, 16'h9001, 16'h0001, 16'h0000);
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0000);	// too early for a tick
		add_step(OP_WAIT, 16'h0000, 16'd11, 16'h0000);	// past reload + 1
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0001);
		add_step(OP_IRQ, 16'h0000, 16'h0001, 16'h0001);
		add_step(OP_WR, 16'h7001, 16'h0003, 16'h0000);
		add_step(OP_PINS, 16'h0000, 16'h002c, 16'h0000);
		add_step(OP_WAIT, 16'h0000, 16'h0003, 16'h0000);
		add_step(OP_PINS, 16'h0000, 16'h002d, 16'h0000);
		add_step(OP_WAIT, 16'h0000, 16'h0004, 16'h0000);
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0003);
		add_step(OP_IRQ, 16'h0000, 16'h0001, 16'h0001);	// timer beats gpio
		add_step(OP_WR, 16'h9001, 16'h0000, 16'h0000);
		add_step(OP_WR, 16'h7000, 16'h0007, 16'h0000);
		add_step(OP_WR, 16'h7001, 16'h0000, 16'h0000);
		add_step(OP_WAIT, 16'h0000, 16'h0001, 16'h0000);
		add_step(OP_IRQ, 16'h0000, 16'h0000, 16'h0000);
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0000);
		build_test = 4;
		add_step(OP_WR, 16'h7001, 16'h0004, 16'h0000);
		add_step(OP_WR, 16'h0000, 16'h3ca5, 16'h0000);	// upper byte not sent
		add_step(OP_RD, 16'h0001, 16'h0000, 16'h0001);
		add_step(OP_FRAME, 16'h0000, 16'h00a5, 16'h0000);
		add_step(OP_POLL, 16'h0001, 16'h0000, 16'h0000);
		add_step(OP_WAIT, 16'h0000, 16'h0002, 16'h0000);
		add_step(OP_RD, 16'h7000, 16'h0000, 16'h0004);
		add_step(OP_IRQ, 16'h0000, 16'h0001, 16'h0003);
		add_step(OP_RD, 16'h0000, 16'h0000, 16'h00a5);
		add_step(OP_TX, 16'h0000, 16'h0000, 16'h0001);
	endtask

	task automatic check_data(string name, data_t got, data_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_irq(string name, irq_num_t got, irq_num_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			$display("Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic idle_bus();
		req = '0;
	endtask

	// 8N1 frame sampled once per bit near mid-bit
	task automatic watch_frame(logic [7:0] byte_exp);
		int wait_cnt;
		wait_cnt = 0;
		while (uart_tx !== 1'b0 && wait_cnt < 2 * BIT_CLKS) begin
			@(negedge CLK);
			wait_cnt++;
		end
		if (uart_tx !== 1'b0) begin
			$display("No start bit on uart_tx within %0d cycles", 2 * BIT_CLKS);
			errors++;
			test_errs++;
		end else begin
			repeat (BIT_CLKS / 2 - 1) @(negedge CLK);
			check_bit("uart_tx start bit", uart_tx, 1'b0);
			for (int i = 0; i < 8; i++) begin
				repeat (BIT_CLKS) @(negedge CLK);
				check_bit($sformatf("uart_tx data bit %0d", i), uart_tx, byte_exp[i]);
			end
			repeat (BIT_CLKS) @(negedge CLK);
			check_bit("uart_tx stop bit", uart_tx, 1'b1);
		end
	endtask

	// keeps reading until the register shows exp
	task automatic poll_read(addr_t addr, data_t exp);
		int n;
		n = 0;
		req.addr = addr;
		req.rd   = 1'b1;
		do begin
			@(negedge CLK);
			n++;
		end while (rdata !== exp && n < POLL_LIMIT);
		idle_bus();
		if (rdata !== exp) begin
			$display("Register %h never reached %h within %0d cycles", addr, exp, POLL_LIMIT);
			errors++;
			test_errs++;
		end
	endtask

	task automatic run_step(step_t s);
		case (s.op)
			OP_WR: begin
				req.addr  = s.addr;
				req.wdata = s.data;
				req.wr    = 1'b1;
				@(negedge CLK);
				idle_bus();
			end
			OP_RD: begin
				req.addr = s.addr;
				req.rd   = 1'b1;
				@(negedge CLK);	// data is back one cycle later
				idle_bus();
				check_data($sformatf("rdata at %h", s.addr), rdata, s.exp);
			end
			OP_WAIT: repeat (int'(s.data)) @(negedge CLK);
			OP_PINS: begin
				gpio_in = s.data[5:0];
				@(negedge CLK);
			end
			OP_OUT: for (int i = 0; i < 4; i++) begin
				check_bit($sformatf("gpio_out[%0d]", i), gpio_out[i], s.exp[i]);
			end
			OP_IRQ: begin
				check_irq("irq", irq, s.exp[3:0]);
				check_bit("interrupt", interrupt, s.data[0]);
			end
			OP_TX: check_bit("uart_tx", uart_tx, s.exp[0]);
			OP_FRAME: watch_frame(s.data[7:0]);
			OP_POLL: poll_read(s.addr, s.exp);
			default: ;
		endcase
	endtask

	task automatic report_test(int idx);
		if (test_errs == 0) begin
			$display("test %0d %s: ok", idx, test_name[idx]);
		end else begin
			$display("test %0d %s: %0d errors", idx, test_name[idx], test_errs);
		end
		tests_done++;
		test_errs = 0;
	endtask

	initial begin
		req         = '0;
		gpio_in     = '0;
		RSTb        = 1'b0;
		errors      = 0;
		checks      = 0;
		test_errs   = 0;
		tests_done  = 0;
		rnd_state   = 32'd95;
		table_ready = 1'b0;
		build_table();
		table_ready = 1'b1;
		repeat (5) @(negedge CLK);
		RSTb     = 1'b1;
		cur_test = 0;
		foreach (steps[i]) begin
			if (int'(steps[i].test) != cur_test) begin
				report_test(cur_test);
				cur_test = int'(steps[i].test);
			end
			run_step(steps[i]);
		end
		report_test(cur_test);
		$display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog sized from the table plus one uart frame
	initial begin
		int limit;
		wait (table_ready === 1'b1);
		limit = steps.size() * 200 + 10 * BIT_CLKS;
		repeat (limit) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* port_controller.sv */
// region decode, per-peripheral write strobes and a two-stage read return
`default_nettype none

module port_controller
	import io_pkg::*;
#(
	parameter int CLOCK_FREQ = 10000000,
	parameter int BAUD_RATE  = 115200
) (
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire io_req_t  req,
	output data_t         rdata,
	input  wire logic [5:0] gpio_in,
	output logic [3:0]    gpio_out,
	output logic          uart_tx,
	output irq_num_t      irq,
	output logic          interrupt
);

	logic [3:0] region;
	logic [3:0] region_q;	// region of the last accepted read
	reg_sel_t   reg_sel;
	ram_addr_t  ram_addr;

	logic wr_uart;
	logic wr_gpio;
	logic wr_intc;
	logic wr_scratch;
	logic wr_timer;

	data_t uart_rdata;
	data_t gpio_rdata;
	data_t intc_rdata;
	data_t timer_rdata;
	data_t ram_rdata;	// already one cycle late

	data_t    periph_sel;
	data_t    periph_q;
	data_t    ret_data;
	data_t    hold_q;
	logic     rd_q;	// second stage of a read
	irq_src_t sources;

	assign region   = req.addr[15:12];
	assign reg_sel  = req.addr[3:0];
	assign ram_addr = req.addr[8:0];

	// one write strobe per region
	assign wr_uart    = req.wr && (region == REGION_UART);
	assign wr_gpio    = req.wr && (region == REGION_GPIO);
	assign wr_intc    = req.wr && (region == REGION_INTC);
	assign wr_scratch = req.wr && (region == REGION_SCRATCH);
	assign wr_timer   = req.wr && (region == REGION_TIMER);

	always_comb begin
		case (region)
			REGION_UART:  periph_sel = uart_rdata;
			REGION_GPIO:  periph_sel = gpio_rdata;
			REGION_INTC:  periph_sel = intc_rdata;
			REGION_TIMER: periph_sel = timer_rdata;
			default:      periph_sel = '0;	// scratch comes from the ram and the rest is unmapped
		endcase
	end

	// stage one captures value and region on a read
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= req.rd;
		end
		if (req.rd) begin
			periph_q <= periph_sel;
			region_q <= region;
		end
	end

	// stage two picks the registered peripheral value or the ram output
	assign ret_data = (region_q == REGION_SCRATCH) ? ram_rdata : periph_q;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			hold_q <= '0;
		end else if (rd_q) begin
			hold_q <= ret_data;	// keep until the next read
		end
	end

	assign rdata = rd_q ? ret_data : hold_q;

	uart_tx #(.CLOCK_FREQ(CLOCK_FREQ), .BAUD_RATE(BAUD_RATE)) u_uart (
		.CLK(CLK), .RSTb(RSTb), .reg_sel(reg_sel), .wdata(req.wdata), .wr(wr_uart),
		.rdata(uart_rdata), .tx(uart_tx), .done_irq(sources[2])
	);

	gpio u_gpio (
		.CLK(CLK), .RSTb(RSTb), .reg_sel(reg_sel), .wdata(req.wdata), .wr(wr_gpio),
		.rdata(gpio_rdata), .pins_in(gpio_in), .pins_out(gpio_out), .edge_irq(sources[1])
	);

	io_timer u_timer (
		.CLK(CLK), .RSTb(RSTb), .reg_sel(reg_sel), .wdata(req.wdata), .wr(wr_timer),
		.rdata(timer_rdata), .tick_irq(sources[0])
	);

	interrupt_controller u_intc (
		.CLK(CLK), .RSTb(RSTb), .reg_sel(reg_sel), .wdata(req.wdata), .wr(wr_intc),
		.rdata(intc_rdata), .sources(sources), .irq(irq), .interrupt(interrupt)
	);

	scratch_ram u_scratch (
		.CLK(CLK), .addr(ram_addr), .wdata(req.wdata), .wr(wr_scratch), .rdata(ram_rdata)
	);

endmodule

`default_nettype wire

/* scratch_ram.sv */
// 512 x 16 single-port ram with synchronous read of the old word
`default_nettype none

module scratch_ram
	import io_pkg::*;
(
	input  wire logic      CLK,
	input  wire ram_addr_t addr,
	input  wire data_t     wdata,
	input  wire logic      wr,
	output data_t          rdata
);

	data_t mem [512];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];	// old word on a write cycle
	end

endmodule

`default_nettype wire

/* interrupt_controller.sv */
// pending and enable registers, write-one-to-clear and priority encoder
`default_nettype none

module interrupt_controller
	import io_pkg::*;
(
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire reg_sel_t reg_sel,
	input  wire data_t    wdata,
	input  wire logic     wr,
	output data_t         rdata,
	input  wire irq_src_t sources,
	output irq_num_t      irq,
	output logic          interrupt
);

	irq_src_t pending;
	irq_src_t enable;
	irq_src_t active;
	irq_src_t clear;

	assign active = pending & enable;

	// ones written to register 0 clear those bits
	assign clear = (wr && (reg_sel == 4'd0)) ? wdata[2:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending   <= '0;
			enable    <= '0;
			interrupt <= 1'b0;
		end else begin
			pending   <= (pending & ~clear) | sources;	// new pulse beats a clear
			interrupt <= |active;
			if (wr && (reg_sel == 4'd1)) begin
				enable <= wdata[2:0];
			end
		end
	end

	// lowest index wins, so scan from the top down
	always_comb begin
		irq = '0;
		for (int i = 2; i >= 0; i--) begin
			if (active[i]) begin
				irq = irq_num_t'(i + 1);
			end
		end
	end

	always_comb begin
		case (reg_sel)
			4'd0:    rdata = {13'd0, pending};
			4'd1:    rdata = {13'd0, enable};
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* io_timer.sv */
// reloadable down counter with enable and terminal-count interrupt
`default_nettype none

module io_timer
	import io_pkg::*;
(
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire reg_sel_t reg_sel,
	input  wire data_t    wdata,
	input  wire logic     wr,
	output data_t         rdata,
	output logic          tick_irq
);

	data_t reload;
	data_t count;
	logic  enable;	// control bit 0
	logic  wr_reload;
	logic  wr_ctrl;

	assign wr_reload = wr && (reg_sel == 4'd0);
	assign wr_ctrl   = wr && (reg_sel == 4'd1);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			reload   <= '0;
			enable   <= 1'b0;
			count    <= '0;
			tick_irq <= 1'b0;
		end else begin
			tick_irq <= 1'b0;
			if (wr_reload) begin
				reload <= wdata;
				count  <= wdata;	// new reload takes effect at once
			end else if (wr_ctrl) begin
				enable <= wdata[0];
				count  <= reload;
			end else if (enable) begin
				if (count == '0) begin
					count    <= reload;
					tick_irq <= 1'b1;	// period is reload + 1
				end else begin
					count <= count - 1'b1;
				end
			end
		end
	end

	always_comb begin
		case (reg_sel)
			4'd0:    rdata = reload;
			4'd1:    rdata = {15'd0, enable};
			4'd2:    rdata = count;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* gpio.sv */
// output and mask registers, input synchronizer and masked rising-edge interrupt
`default_nettype none

module gpio
	import io_pkg::*;
(
	input  wire logic       CLK,
	input  wire logic       RSTb,
	input  wire reg_sel_t   reg_sel,
	input  wire data_t      wdata,
	input  wire logic       wr,
	output data_t           rdata,
	input  wire logic [5:0] pins_in,
	output logic [3:0]      pins_out,
	output logic            edge_irq
);

	logic [5:0] sync1;
	logic [5:0] sync2;	// visible in register 1
	logic [5:0] prev;	// sync2 one cycle back
	logic [5:0] mask;
	logic [5:0] rose;

	assign rose = sync2 & ~prev & mask;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pins_out <= '0;
			mask     <= '0;
			sync1    <= '0;
			sync2    <= '0;
			prev     <= '0;
			edge_irq <= 1'b0;
		end else begin
			sync1    <= pins_in;
			sync2    <= sync1;
			prev     <= sync2;
			edge_irq <= |rose;	// one cycle per edge
			if (wr) begin
				case (reg_sel)
					4'd0:    pins_out <= wdata[3:0];
					4'd2:    mask     <= wdata[5:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		case (reg_sel)
			4'd0:    rdata = {12'd0, pins_out};
			4'd1:    rdata = {10'd0, sync2};
			4'd2:    rdata = {10'd0, mask};
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* uart_tx.sv */
// 8N1 transmitter with data and busy registers and an end-of-frame interrupt
`default_nettype none

module uart_tx
	import io_pkg::*;
#(
	parameter int CLOCK_FREQ = 10000000,
	parameter int BAUD_RATE  = 115200
) (
	input  wire logic     CLK,
	input  wire logic     RSTb,
	input  wire reg_sel_t reg_sel,
	input  wire data_t    wdata,
	input  wire logic     wr,
	output data_t         rdata,
	output logic          tx,
	output logic          done_irq
);

	localparam int BIT_CYCLES = CLOCK_FREQ / BAUD_RATE;
	localparam int CNT_W      = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

	uart_state_t    state;
	logic [CNT_W-1:0] baud_cnt;
	logic [2:0]     bit_idx;
	logic [7:0]     shift;
	logic [7:0]     last_data;
	logic           busy;
	logic           bit_end;
	logic           start_wr;

	assign busy     = (state != UART_IDLE);
	assign bit_end  = (baud_cnt == CNT_W'(BIT_CYCLES - 1));
	assign start_wr = wr && (reg_sel == 4'd0) && !busy;	// ignored while busy

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state     <= UART_IDLE;
			tx        <= 1'b1;
			baud_cnt  <= '0;
			bit_idx   <= '0;
			last_data <= '0;
			done_irq  <= 1'b0;
		end else begin
			done_irq <= 1'b0;
			baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
			case (state)
				UART_IDLE: if (start_wr) begin
					state     <= UART_START;
					tx        <= 1'b0;	// start bit
					baud_cnt  <= '0;
					shift     <= wdata[7:0];
					last_data <= wdata[7:0];
				end
				UART_START: if (bit_end) begin
					state   <= UART_DATA;
					tx      <= shift[0];	// lsb first
					shift   <= shift >> 1;
					bit_idx <= '0;
				end
				UART_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						state <= UART_STOP;
						tx    <= 1'b1;
					end else begin
						tx      <= shift[0];
						shift   <= shift >> 1;
						bit_idx <= bit_idx + 1'b1;
					end
				end
				UART_STOP: if (bit_end) begin
					state    <= UART_IDLE;
					done_irq <= 1'b1;	// frame finished
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

	always_comb begin
		case (reg_sel)
			4'd0:    rdata = {8'h00, last_data};
			4'd1:    rdata = {15'd0, busy};
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* io_pkg.sv */
// bus and register types, request struct, region codes and uart state enum
`default_nettype none

package io_pkg;

	typedef logic [15:0] data_t;	// bus data word
	typedef logic [15:0] addr_t;	// cpu i/o address
	typedef logic [3:0]  reg_sel_t;	// register inside a peripheral
	typedef logic [8:0]  ram_addr_t;	// scratch-pad word address

	// bit 0 timer, bit 1 gpio, bit 2 uart; bit 0 wins
	typedef logic [2:0] irq_src_t;

	// 0 when idle, else source index + 1
	typedef logic [3:0] irq_num_t;

	// one cpu access as seen at the controller
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  wr;	// write strobe
		logic  rd;	// read strobe
	} io_req_t;

	// address bits 15:12
	localparam logic [3:0] REGION_UART    = 4'h0;
	localparam logic [3:0] REGION_GPIO    = 4'h1;
	localparam logic [3:0] REGION_INTC    = 4'h7;
	localparam logic [3:0] REGION_SCRATCH = 4'h8;
	localparam logic [3:0] REGION_TIMER   = 4'h9;

	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_t;

endpackage

`default_nettype wire
